//--- all.f
sync_pkg.sv
handshake_pkg.sv
pulse_sync.sv
word_crossing.sv
src_sender.sv
dst_receiver.sv
data_handshake.sv
tb_clock_gen.sv
data_handshake_checker.sv
data_handshake_monitor.sv
data_handshake_tb.sv

//--- data_handshake.sv
`timescale 1ns/100ps

module data_handshake #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                  src_clk,
    input  logic                  src_rst,
    input  logic                  dst_clk,
    input  logic                  dst_rst,
    input  logic [DATA_WIDTH-1:0] data_in,
    input  logic                  valid_in,
    output logic                  rdy,
    output logic                  done,
    output logic [DATA_WIDTH-1:0] data_out,
    output logic                  valid_out
);

    logic                  rst_req_src;    // reset request, source side
    logic                  rst_req_dst;
    logic                  rst_done_dst;   // reset reply, destination side
    logic                  rst_done_src;
    logic                  xfer_done_dst;
    logic                  xfer_done_src;
    logic [DATA_WIDTH-1:0] send_word;
    logic                  send_req;
    logic                  send_ack;
    logic [DATA_WIDTH-1:0] recv_word;
    logic                  recv_valid;
    logic                  recv_ack;

    src_sender #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_src_sender (
        .src_clk   (src_clk),
        .src_rst   (src_rst),
        .data_in   (data_in),
        .valid_in  (valid_in),
        .rdy       (rdy),
        .done      (done),
        .rst_req   (rst_req_src),
        .rst_done  (rst_done_src),
        .xfer_done (xfer_done_src),
        .send_word (send_word),
        .send_req  (send_req),
        .send_ack  (send_ack)
    );

    word_crossing #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_word_crossing (
        .src_clk    (src_clk),
        .src_rst    (src_rst),
        .send_word  (send_word),
        .send_req   (send_req),
        .send_ack   (send_ack),
        .dst_clk    (dst_clk),
        .dst_rst    (dst_rst),
        .recv_word  (recv_word),
        .recv_valid (recv_valid),
        .recv_ack   (recv_ack)
    );

    dst_receiver #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_dst_receiver (
        .dst_clk    (dst_clk),
        .dst_rst    (dst_rst),
        .rst_req    (rst_req_dst),
        .rst_done   (rst_done_dst),
        .recv_word  (recv_word),
        .recv_valid (recv_valid),
        .recv_ack   (recv_ack),
        .xfer_done  (xfer_done_dst),
        .data_out   (data_out),
        .valid_out  (valid_out)
    );

    // source to destination
    pulse_sync rst_req_sync (
        .in_clk    (src_clk),
        .in_rst    (src_rst),
        .pulse_in  (rst_req_src),
        .out_clk   (dst_clk),
        .out_rst   (dst_rst),
        .pulse_out (rst_req_dst)
    );

    // destination to source
    pulse_sync rst_done_sync (
        .in_clk    (dst_clk),
        .in_rst    (dst_rst),
        .pulse_in  (rst_done_dst),
        .out_clk   (src_clk),
        .out_rst   (src_rst),
        .pulse_out (rst_done_src)
    );

    pulse_sync xfer_done_sync (
        .in_clk    (dst_clk),
        .in_rst    (dst_rst),
        .pulse_in  (xfer_done_dst),
        .out_clk   (src_clk),
        .out_rst   (src_rst),
        .pulse_out (xfer_done_src)
    );

endmodule

//--- data_handshake_checker.sv
`timescale 1ns/100ps

module data_handshake_checker (
    input logic                      src_clk,
    input logic                      src_rst,
    input logic                      dst_clk,
    input logic                      dst_rst,
    input logic                      rdy,
    input logic                      done,
    input logic                      send_req,
    input logic                      valid_out,
    input handshake_pkg::src_state_t src_state,
    input handshake_pkg::dst_state_t dst_state
);

    int failures = 0;

    done_single: assert property (@(posedge src_clk) disable iff (src_rst) done |=> !done)
        else begin
            failures++;
            $error("done stayed high for a second src_clk cycle");
        end

    valid_single: assert property (@(posedge dst_clk) disable iff (dst_rst)
        valid_out |=> !valid_out)
        else begin
            failures++;
            $error("valid_out stayed high for a second dst_clk cycle");
        end

    // the source may only offer a new slot once its request is down
    rdy_after_release: assert property (@(posedge src_clk) disable iff (src_rst)
        $rose(rdy) |-> !send_req)
        else begin
            failures++;
            $error("rdy rose while send_req was still high");
        end

    src_state_legal: assert property (@(posedge src_clk) disable iff (src_rst)
        src_state inside {handshake_pkg::WAIT_RESET_DONE, handshake_pkg::IDLE,
            handshake_pkg::REQUEST, handshake_pkg::WAIT_ACK, handshake_pkg::RELEASE})
        else begin
            failures++;
            $error("source controller in an illegal state");
        end

    dst_state_legal: assert property (@(posedge dst_clk) disable iff (dst_rst)
        dst_state inside {handshake_pkg::RESET_REPLY, handshake_pkg::GET_DATA,
            handshake_pkg::SEND_ACK})
        else begin
            failures++;
            $error("destination controller in an illegal state");
        end

endmodule

bind data_handshake data_handshake_checker checks (
    .src_clk   (src_clk),
    .src_rst   (src_rst),
    .dst_clk   (dst_clk),
    .dst_rst   (dst_rst),
    .rdy       (rdy),
    .done      (done),
    .send_req  (send_req),
    .valid_out (valid_out),
    .src_state (u_src_sender.state),
    .dst_state (u_dst_receiver.state)
);

//--- data_handshake_monitor.sv
`timescale 1ns/100ps

module data_handshake_monitor #(
    parameter int DATA_WIDTH = 32
) (
    input logic                  src_clk,
    input logic                  src_rst,
    input logic                  dst_clk,
    input logic                  dst_rst,
    input logic                  valid_in,
    input logic                  rdy,
    input logic                  done,
    input logic [DATA_WIDTH-1:0] data_out,
    input logic                  valid_out
);

    logic [DATA_WIDTH-1:0] expected_q[$];
    int                    value_errors = 0;
    int                    protocol_errors = 0;
    int                    accepted = 0;
    int                    done_pulses = 0;
    logic                  in_flight = 1'b0;  // a word was taken and its done is still owed

    task automatic expect_word(input logic [DATA_WIDTH-1:0] word);
        expected_q.push_back(word);
    endtask

    function automatic int pending();
        return expected_q.size();
    endfunction

    // valid_out changes on the rising edge so the falling edge sees it settled
    always @(negedge dst_clk) begin : output_check
        logic [DATA_WIDTH-1:0] expected;
        if (!dst_rst && valid_out === 1'b1) begin
            if (expected_q.size() == 0) begin
                $display("extra word %h on data_out at %0t", data_out, $time);
                protocol_errors++;
            end else begin
                expected = expected_q.pop_front();
                if (data_out !== expected) begin
                    $display("ERROR at %0t: data_out expected %h got %h",
                             $time, expected, data_out);
                    value_errors++;
                end
            end
        end
    end

    // source side is seen with the values the DUT itself samples
    always @(posedge src_clk) begin : source_check
        if (src_rst) begin
            in_flight = 1'b0;
        end else begin
            // rdy must stay low up to and including the done cycle
            if (rdy === 1'b1 && in_flight) begin
                $display("rdy high at %0t before done of the word in flight", $time);
                protocol_errors++;
            end
            if (done === 1'b1) begin
                if (!in_flight) begin
                    $display("done pulsed at %0t with no word in flight", $time);
                    protocol_errors++;
                end
                done_pulses++;
                in_flight = 1'b0;
            end
            if (valid_in === 1'b1 && rdy === 1'b1) begin
                accepted++;
                in_flight = 1'b1;
            end
        end
    end

    task automatic final_check();
        if (expected_q.size() != 0) begin
            $display("%0d expected words never appeared on data_out", expected_q.size());
            protocol_errors += expected_q.size();
        end
        if (accepted != done_pulses) begin
            $display("%0d words accepted but %0d done pulses seen", accepted, done_pulses);
            protocol_errors++;
        end
    endtask

endmodule

//--- data_handshake_stim.txt
# columns: command, data word in hex, idle gap in src_clk cycles, expected data_out in hex
# the expected column stays empty where no word may come out
send 00000001 0 00000001
send a5a5a5a5 2 a5a5a5a5
send 5a5a5a5a 0 5a5a5a5a
send_while_busy deadbeef 0
send ffffffff 1 ffffffff
send 00000000 3 00000000
send 12345678 0 12345678
send_while_busy 0badf00d 2
src_reset 0 5
send 87654321 0 87654321
send c3c3c3c3 4 c3c3c3c3
send 80000000 0 80000000
send_while_busy 11111111 0
src_reset 0 0
send 00000001 1 00000001
send 7fffffff 0 7fffffff
send 0f0f0f0f 2 0f0f0f0f

//--- data_handshake_tb.sv
`timescale 1ns/100ps

module data_handshake_tb;

    localparam int DATA_WIDTH   = 32;
    localparam int WAIT_LIMIT   = 500;  // src_clk cycles allowed for any single wait
    localparam int RESET_LENGTH = 4;    // src_clk cycles of a mid-run source reset

    logic                  src_clk;
    logic                  dst_clk;
    logic                  src_por;
    logic                  dst_por;
    logic                  src_rst_cmd;
    logic                  src_rst;
    logic                  dst_rst;
    logic [DATA_WIDTH-1:0] data_in;
    logic                  valid_in;
    logic                  rdy;
    logic                  done;
    logic [DATA_WIDTH-1:0] data_out;
    logic                  valid_out;
    int                    other_errors = 0;
    int                    timeouts = 0;

    assign src_rst = src_por | src_rst_cmd;
    assign dst_rst = dst_por;

    tb_clock_gen #(
        .SRC_PERIOD   (34.0),
        .DST_PERIOD   (40.0),
        .RESET_CYCLES (16)
    ) clocks (
        .src_clk (src_clk),
        .dst_clk (dst_clk),
        .src_por (src_por),
        .dst_por (dst_por)
    );

    data_handshake #(.DATA_WIDTH (DATA_WIDTH)) UUT (
        .src_clk   (src_clk),
        .src_rst   (src_rst),
        .dst_clk   (dst_clk),
        .dst_rst   (dst_rst),
        .data_in   (data_in),
        .valid_in  (valid_in),
        .rdy       (rdy),
        .done      (done),
        .data_out  (data_out),
        .valid_out (valid_out)
    );

    data_handshake_monitor #(.DATA_WIDTH (DATA_WIDTH)) monitor (
        .src_clk   (src_clk),
        .src_rst   (src_rst),
        .dst_clk   (dst_clk),
        .dst_rst   (dst_rst),
        .valid_in  (valid_in),
        .rdy       (rdy),
        .done      (done),
        .data_out  (data_out),
        .valid_out (valid_out)
    );

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s expected %b got %b", $time, name, expected, actual);
            other_errors++;
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while ((src_rst !== 1'b0 || dst_rst !== 1'b0) && cycles < WAIT_LIMIT) begin
            @(negedge src_clk);
            cycles++;
        end
        if (src_rst !== 1'b0 || dst_rst !== 1'b0) begin
            $display("timeout at %0t while waiting for the resets to end", $time);
            timeouts++;
        end
    endtask

    task automatic wait_for_rdy();
        int cycles;
        cycles = 0;
        while (rdy !== 1'b1 && cycles < WAIT_LIMIT) begin
            @(negedge src_clk);
            cycles++;
        end
        if (rdy !== 1'b1) begin
            $display("timeout at %0t while waiting for rdy", $time);
            timeouts++;
        end
    endtask

    task automatic drive_valid(input logic [DATA_WIDTH-1:0] word);
        data_in  = word;
        valid_in = 1'b1;
        @(negedge src_clk);
        valid_in = 1'b0;
    endtask

    // outputs must be quiet while the source is held in reset
    task automatic reset_source();
        wait_for_rdy();
        src_rst_cmd = 1'b1;
        repeat (RESET_LENGTH) @(negedge src_clk);
        check_bit("rdy", 1'b0, rdy);
        check_bit("done", 1'b0, done);
        check_bit("valid_out", 1'b0, valid_out);
        src_rst_cmd = 1'b0;
        wait_for_rdy();
    endtask

    initial begin
        int                    fd;
        int                    fields;
        int                    gap;
        int                    cycles;
        int                    errors;
        string                 line;
        string                 cmd;
        logic [DATA_WIDTH-1:0] word;
        logic [DATA_WIDTH-1:0] expected;

        src_rst_cmd = 1'b0;
        valid_in    = 1'b0;
        data_in     = '0;
        void'($urandom(6847));

        wait_reset_release();
        check_bit("rdy", 1'b0, rdy);
        check_bit("done", 1'b0, done);
        check_bit("valid_out", 1'b0, valid_out);
        wait_for_rdy();

        fd = $fopen("data_handshake_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open data_handshake_stim.txt");
            other_errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                cmd    = "";
                fields = $sscanf(line, "%s %h %d %h", cmd, word, gap, expected);
                if (fields >= 1 && cmd != "#") begin
                    if (fields < 3) begin
                        $display("stim line with missing columns: %s", line);
                        other_errors++;
                    end else begin
                        if (fields == 4) begin
                            monitor.expect_word(expected);
                        end
                        if (cmd == "send") begin
                            wait_for_rdy();
                            drive_valid(word);
                        end else if (cmd == "send_while_busy") begin
                            if (rdy === 1'b1) begin
                                $display("send_while_busy at %0t found rdy high", $time);
                                other_errors++;
                            end
                            drive_valid(word);
                        end else if (cmd == "src_reset") begin
                            reset_source();
                        end else begin
                            $display("unknown stim command: %s", cmd);
                            other_errors++;
                        end
                        repeat (gap + $urandom % 3) @(negedge src_clk);
                    end
                end
            end
            $fclose(fd);
        end

        wait_for_rdy();
        cycles = 0;
        while (monitor.pending() != 0 && cycles < WAIT_LIMIT) begin
            @(negedge src_clk);
            cycles++;
        end
        monitor.final_check();

        errors = other_errors + timeouts + monitor.value_errors + monitor.protocol_errors
                 + UUT.checks.failures;
        $display("errors: %0d data, %0d protocol, %0d assertion, %0d timeout, %0d other",
                 monitor.value_errors, monitor.protocol_errors, UUT.checks.failures,
                 timeouts, other_errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- dst_receiver.sv
`timescale 1ns/100ps

module dst_receiver #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                  dst_clk,
    input  logic                  dst_rst,
    input  logic                  rst_req,
    output logic                  rst_done,
    input  logic [DATA_WIDTH-1:0] recv_word,
    input  logic                  recv_valid,
    output logic                  recv_ack,
    output logic                  xfer_done,
    output logic [DATA_WIDTH-1:0] data_out,
    output logic                  valid_out
);

    handshake_pkg::dst_state_t state;

    always_ff @(posedge dst_clk) begin
        if (dst_rst || rst_req) begin
            // a request from the source resets this side like a local reset
            state     <= handshake_pkg::RESET_REPLY;
            rst_done  <= 1'b0;
            recv_ack  <= 1'b0;
            xfer_done <= 1'b0;
            data_out  <= '0;
            valid_out <= 1'b0;
        end else begin
            rst_done  <= 1'b0;
            xfer_done <= 1'b0;
            valid_out <= 1'b0;

            case (state)
                handshake_pkg::RESET_REPLY: begin
                    rst_done <= 1'b1;
                    state    <= handshake_pkg::GET_DATA;
                end

                handshake_pkg::GET_DATA: begin
                    if (recv_valid) begin
                        data_out  <= recv_word;
                        valid_out <= 1'b1;
                        xfer_done <= 1'b1;
                        recv_ack  <= 1'b1;
                        state     <= handshake_pkg::SEND_ACK;
                    end
                end

                // the word is taken, wait here until the source drops its request
                handshake_pkg::SEND_ACK: begin
                    if (!recv_valid) begin
                        recv_ack <= 1'b0;
                        state    <= handshake_pkg::GET_DATA;
                    end
                end

                default: begin
                    recv_ack <= 1'b0;
                    state    <= handshake_pkg::RESET_REPLY;
                end
            endcase
        end
    end

endmodule

//--- handshake_pkg.sv
package handshake_pkg;

    // source controller states
    typedef enum logic [2:0] {
        WAIT_RESET_DONE,
        IDLE,
        REQUEST,
        WAIT_ACK,
        RELEASE
    } src_state_t;

    // destination controller states
    typedef enum logic [1:0] {
        RESET_REPLY,
        GET_DATA,
        SEND_ACK
    } dst_state_t;

endpackage

//--- pulse_sync.sv
`timescale 1ns/100ps

module pulse_sync (
    input  logic in_clk,
    input  logic in_rst,
    input  logic pulse_in,
    input  logic out_clk,
    input  logic out_rst,
    output logic pulse_out
);

    localparam int MSB = sync_pkg::SYNC_STAGES - 1;

    logic                  toggle = 1'b0;  // every change of phase is one pulse
    sync_pkg::sync_chain_t chain;
    logic                  seen;           // phase already turned into a pulse

    // input domain flips the phase once per pulse
    always_ff @(posedge in_clk) begin
        if (!in_rst && pulse_in) begin
            toggle <= ~toggle;
        end
    end

    // output domain resamples the phase and marks each change with one cycle
    always_ff @(posedge out_clk) begin
        chain <= {chain[MSB-1:0], toggle};
        seen  <= chain[MSB];
        if (out_rst) begin
            pulse_out <= 1'b0;  // changes arriving during reset are swallowed
        end else begin
            pulse_out <= chain[MSB] ^ seen;
        end
    end

endmodule

//--- src_sender.sv
`timescale 1ns/100ps

module src_sender #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                  src_clk,
    input  logic                  src_rst,
    input  logic [DATA_WIDTH-1:0] data_in,
    input  logic                  valid_in,
    output logic                  rdy,
    output logic                  done,
    output logic                  rst_req,
    input  logic                  rst_done,
    input  logic                  xfer_done,
    output logic [DATA_WIDTH-1:0] send_word,
    output logic                  send_req,
    input  logic                  send_ack
);

    handshake_pkg::src_state_t state;
    logic                      rst_pending;  // reset request still owed to the destination
    logic                      xfer_seen;    // destination has sampled the current word

    assign rdy  = (state == handshake_pkg::IDLE);
    assign done = (state == handshake_pkg::RELEASE);

    always_ff @(posedge src_clk) begin
        if (src_rst) begin
            state       <= handshake_pkg::WAIT_RESET_DONE;
            rst_pending <= 1'b1;
            rst_req     <= 1'b0;
            send_req    <= 1'b0;
            xfer_seen   <= 1'b0;
        end else begin
            // the request goes out once, on the first cycle after reset
            rst_req     <= rst_pending;
            rst_pending <= 1'b0;

            if (xfer_done) begin
                xfer_seen <= 1'b1;
            end

            case (state)
                handshake_pkg::WAIT_RESET_DONE: begin
                    if (rst_done) begin
                        state <= handshake_pkg::IDLE;
                    end
                end

                handshake_pkg::IDLE: begin
                    if (valid_in) begin
                        send_word <= data_in;
                        send_req  <= 1'b1;
                        xfer_seen <= 1'b0;
                        state     <= handshake_pkg::REQUEST;
                    end
                end

                // hold the word and the request until the acknowledge is back
                handshake_pkg::REQUEST: begin
                    if (send_ack) begin
                        send_req <= 1'b0;
                        state    <= handshake_pkg::WAIT_ACK;
                    end
                end

                handshake_pkg::WAIT_ACK: begin
                    if (!send_ack && (xfer_seen || xfer_done)) begin
                        state <= handshake_pkg::RELEASE;  // four phases complete
                    end
                end

                handshake_pkg::RELEASE: begin
                    state <= handshake_pkg::IDLE;
                end

                default: begin
                    send_req <= 1'b0;
                    state    <= handshake_pkg::WAIT_RESET_DONE;
                end
            endcase
        end
    end

endmodule

//--- sync_pkg.sv
package sync_pkg;

    // flip-flops in each synchronizer chain, two is the usual minimum
    localparam int SYNC_STAGES = 2;

    // one chain of synchronizer flops, bit 0 samples the foreign domain
    typedef logic [SYNC_STAGES-1:0] sync_chain_t;

endpackage

//--- tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter real SRC_PERIOD   = 34.0,
    parameter real DST_PERIOD   = 40.0,
    parameter int  RESET_CYCLES = 16
) (
    output logic src_clk,
    output logic dst_clk,
    output logic src_por,
    output logic dst_por
);

    initial begin
        src_clk = 1'b0;
        dst_clk = 1'b0;
        src_por = 1'b1;
        dst_por = 1'b1;
    end

    always #(SRC_PERIOD / 2.0) src_clk = ~src_clk;
    always #(DST_PERIOD / 2.0) dst_clk = ~dst_clk;

    // each reset is released on a falling edge of its own clock
    initial begin
        repeat (RESET_CYCLES) @(posedge src_clk);
        @(negedge src_clk);
        src_por = 1'b0;
    end

    initial begin
        repeat (RESET_CYCLES) @(posedge dst_clk);
        @(negedge dst_clk);
        dst_por = 1'b0;
    end

endmodule

//--- word_crossing.sv
`timescale 1ns/100ps

module word_crossing #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                  src_clk,
    input  logic                  src_rst,
    input  logic [DATA_WIDTH-1:0] send_word,
    input  logic                  send_req,
    output logic                  send_ack,
    input  logic                  dst_clk,
    input  logic                  dst_rst,
    output logic [DATA_WIDTH-1:0] recv_word,
    output logic                  recv_valid,
    input  logic                  recv_ack
);

    localparam int MSB = sync_pkg::SYNC_STAGES - 1;

    logic                  req_q;     // request level as seen by the other domain
    logic [DATA_WIDTH-1:0] word_q;
    sync_pkg::sync_chain_t req_sync;  // request level into dst_clk
    sync_pkg::sync_chain_t ack_sync;  // acknowledge level back into src_clk

    // source side

    always_ff @(posedge src_clk) begin
        if (src_rst) begin
            req_q <= 1'b0;
        end else begin
            req_q <= send_req;
        end
    end

    // the word is loaded on the same edge that raises req_q, so it is settled
    // before the request can be seen in dst_clk
    always_ff @(posedge src_clk) begin
        if (send_req && !req_q) begin
            word_q <= send_word;
        end
    end

    always_ff @(posedge src_clk) begin
        if (src_rst) begin
            ack_sync <= '0;
        end else begin
            ack_sync <= {ack_sync[MSB-1:0], recv_ack};
        end
    end

    assign send_ack = ack_sync[MSB];

    // destination side

    always_ff @(posedge dst_clk) begin
        if (dst_rst) begin
            req_sync <= '0;
        end else begin
            req_sync <= {req_sync[MSB-1:0], req_q};
        end
    end

    assign recv_valid = req_sync[MSB];
    assign recv_word  = word_q;  // held still for as long as the request is up

endmodule
